//--- common/db_pkg.sv
package db_pkg;

    // ==========================================================
    // Control port command
    // ==========================================================

    // Codes 5 to 7 are illegal and complete with ERROR
    typedef enum logic [2:0] {
        NOP   = 3'd0,
        GET   = 3'd1,
        SET   = 3'd2,
        UNSET = 3'd3,
        CLEAR = 3'd4
    } command_t;

    // ==========================================================
    // Completion status
    // ==========================================================

    typedef enum logic {
        OK    = 1'b0,
        ERROR = 1'b1
    } status_t;

endpackage : db_pkg

//--- db_ctrl.f
+incdir+verif
common/db_pkg.sv
db_ctrl/db_ctrl_prio_mux.sv
db_ctrl/db_ctrl_peripheral.sv
verilog/db_store_array.sv
verilog/db_subsys_top.sv
verif/db_subsys_tb.sv

//--- db_ctrl/db_ctrl_peripheral.sv
module db_ctrl_peripheral
    import db_pkg::*;
#(
    parameter int KEY_WID   = 8,
    parameter int VALUE_WID = 32
) (
    input  logic                 clk,
    input  logic                 srst,

    // Control port
    input  logic                 req,
    input  command_t             command,
    input  logic [KEY_WID-1:0]   key,
    input  logic [VALUE_WID-1:0] set_value,
    output logic                 rdy,
    output logic                 ack,
    output status_t              status,
    output logic                 get_valid,
    output logic [VALUE_WID-1:0] get_value,

    // Store
    output logic                 init,
    input  logic                 init_done,
    output logic                 wr_en,
    output logic [KEY_WID-1:0]   wr_key,
    output logic                 wr_valid,
    output logic [VALUE_WID-1:0] wr_value,
    output logic                 rd_en,
    output logic [KEY_WID-1:0]   rd_key,
    input  logic                 rd_valid_out,
    input  logic [VALUE_WID-1:0] rd_value
);

    typedef enum logic [2:0] {
        ST_INIT,
        ST_IDLE,
        ST_EXEC,
        ST_RESP,
        ST_CLEAR
    } state_t;

    state_t               state;
    state_t               state_nxt;
    command_t             cmd_q;
    logic [KEY_WID-1:0]   key_q;
    logic [VALUE_WID-1:0] value_q;
    logic                 cmd_legal;
    logic                 accept;

    assign accept = req && rdy;

    // ==========================================================
    // Sequencer
    // ==========================================================

    always_comb begin
        state_nxt = state;
        case (state)
            ST_INIT:  if (init_done) state_nxt = ST_IDLE;
            ST_IDLE:  if (accept) state_nxt = ST_EXEC;
            ST_EXEC:  state_nxt = (cmd_q == CLEAR) ? ST_CLEAR : ST_RESP;
            ST_CLEAR: if (init_done) state_nxt = ST_RESP;
            ST_RESP:  state_nxt = ST_IDLE;
            default:  state_nxt = ST_INIT;
        endcase
    end

    // Power-up sweep starts straight out of reset
    always_ff @(posedge clk) begin
        if (srst) begin
            state <= ST_INIT;
        end else begin
            state <= state_nxt;
        end
    end

    // Command capture on accept
    always_ff @(posedge clk) begin
        if (accept) begin
            cmd_q   <= command;
            key_q   <= key;
            value_q <= set_value;
        end
    end

    // ==========================================================
    // Decode and store drive
    // ==========================================================

    always_comb begin
        case (cmd_q)
            NOP, GET, SET, UNSET, CLEAR: cmd_legal = 1'b1;
            default:                     cmd_legal = 1'b0;
        endcase
    end

    assign init = (state == ST_INIT) || (state == ST_CLEAR);

    assign rd_en  = (state == ST_EXEC) && (cmd_q == GET);
    assign rd_key = key_q;

    assign wr_en    = (state == ST_EXEC) && ((cmd_q == SET) || (cmd_q == UNSET));
    assign wr_key   = key_q;
    assign wr_valid = (cmd_q == SET);
    assign wr_value = value_q;

    // Read data lands in the ack cycle
    assign rdy       = (state == ST_IDLE);
    assign ack       = (state == ST_RESP);
    assign status    = cmd_legal ? OK : ERROR;
    assign get_valid = (cmd_q == GET) && rd_valid_out;
    assign get_value = rd_value;

    // Every command but CLEAR acks two cycles after its accept
    a_ack_latency : assert property (
        @(posedge clk) disable iff (srst) $past(accept && (command != CLEAR), 2) |-> ack
    );

endmodule : db_ctrl_peripheral

//--- db_ctrl/db_ctrl_prio_mux.sv
module db_ctrl_prio_mux
    import db_pkg::*;
#(
    parameter int KEY_WID   = 8,
    parameter int VALUE_WID = 32
) (
    input  logic                 clk,
    input  logic                 srst,

    // High-priority controller
    input  logic                 hi_req,
    input  command_t             hi_command,
    input  logic [KEY_WID-1:0]   hi_key,
    input  logic [VALUE_WID-1:0] hi_set_value,
    output logic                 hi_rdy,
    output logic                 hi_ack,
    output status_t              hi_status,
    output logic                 hi_get_valid,
    output logic [VALUE_WID-1:0] hi_get_value,

    // Low-priority controller
    input  logic                 lo_req,
    input  command_t             lo_command,
    input  logic [KEY_WID-1:0]   lo_key,
    input  logic [VALUE_WID-1:0] lo_set_value,
    output logic                 lo_rdy,
    output logic                 lo_ack,
    output status_t              lo_status,
    output logic                 lo_get_valid,
    output logic [VALUE_WID-1:0] lo_get_value,

    // Toward the peripheral
    output logic                 per_req,
    output command_t             per_command,
    output logic [KEY_WID-1:0]   per_key,
    output logic [VALUE_WID-1:0] per_set_value,
    input  logic                 per_rdy,
    input  logic                 per_ack,
    input  status_t              per_status,
    input  logic                 per_get_valid,
    input  logic [VALUE_WID-1:0] per_get_value
);

    logic locked;
    logic lock_lo;
    logic sel_lo;

    // ==========================================================
    // Arbitration and grant lock
    // ==========================================================

    // Fixed priority while free, held port while locked
    assign sel_lo = locked ? lock_lo : (!hi_req && lo_req);

    always_ff @(posedge clk) begin
        if (srst) begin
            locked  <= 1'b0;
            lock_lo <= 1'b0;
        end else if (per_ack) begin
            locked  <= 1'b0;
        end else if (per_req && per_rdy) begin
            locked  <= 1'b1;
            lock_lo <= sel_lo;
        end
    end

    // Request side steering
    assign per_req       = sel_lo ? lo_req       : hi_req;
    assign per_command   = sel_lo ? lo_command   : hi_command;
    assign per_key       = sel_lo ? lo_key       : hi_key;
    assign per_set_value = sel_lo ? lo_set_value : hi_set_value;

    // Only the selected port sees rdy
    assign hi_rdy = per_rdy && !sel_lo;
    assign lo_rdy = per_rdy && sel_lo;

    // Ack goes back to the port holding the lock
    assign hi_ack = per_ack && locked && !lock_lo;
    assign lo_ack = per_ack && locked && lock_lo;

    // Response payload is only meaningful with ack
    assign hi_status    = per_status;
    assign hi_get_valid = per_get_valid;
    assign hi_get_value = per_get_value;
    assign lo_status    = per_status;
    assign lo_get_valid = per_get_valid;
    assign lo_get_value = per_get_value;

    // ==========================================================
    // Assertions
    // ==========================================================

    // Peripheral only acks a command this mux handed over
    a_ack_needs_lock : assert property (
        @(posedge clk) disable iff (srst) per_ack |-> locked
    );

    // Neither port sees rdy while a command is in flight
    a_no_rdy_while_locked : assert property (
        @(posedge clk) disable iff (srst) locked |-> !(hi_rdy || lo_rdy)
    );

endmodule : db_ctrl_prio_mux

//--- run_sim.sh
#!/usr/bin/env bash
# Build and run the subsystem testbench with Verilator.
# The result is read from sim.log in the project root.

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal \
    --top-module db_subsys_tb \
    -f db_ctrl.f \
    -o db_subsys_sim > sim.log 2>&1 \
    && ./obj_dir/db_subsys_sim >> sim.log 2>&1 \
    || { echo "Build or simulation error, see sim.log"; exit 1; }

grep -q '\*\* FAIL \*\*' sim.log \
    && { echo "Simulation reported failure, see sim.log"; exit 1; }

echo "Simulation finished without failure"
exit 0

//--- verif/db_subsys_tb_tasks.svh
`ifndef DB_SUBSYS_TB_TASKS_SVH
`define DB_SUBSYS_TB_TASKS_SVH

    // ==========================================================
    // Reference model
    // ==========================================================

    // A missing key reads as not valid
    logic [VALUE_WID-1:0] model_mem [logic [KEY_WID-1:0]];

    function automatic void model_op(input command_t cmd, input logic [KEY_WID-1:0] key,
            input logic [VALUE_WID-1:0] value, output status_t st, output logic vld,
            output logic [VALUE_WID-1:0] val);
        st  = OK;
        vld = 1'b0;
        val = '0;
        case (cmd)
            NOP: ;
            GET: begin
                if (model_mem.exists(key)) begin
                    vld = 1'b1;
                    val = model_mem[key];
                end
            end
            SET:   model_mem[key] = value;
            UNSET: if (model_mem.exists(key)) model_mem.delete(key);
            CLEAR: model_mem.delete();
            default: st = ERROR;
        endcase
    endfunction

    function automatic string label_of(input int port);
        return (port == LO) ? "lo" : "hi";
    endfunction

    function automatic logic rdy_of(input int port);
        return (port == LO) ? lo_rdy : hi_rdy;
    endfunction

    // ==========================================================
    // Checks and reporting
    // ==========================================================

    task automatic flag_error(input string msg);
        errors++;
        $display("%s", msg);
    endtask

    task automatic check_status(input string name, input status_t expected, input status_t got);
        checks++;
        if (got !== expected) begin
            errors++;
            $display("Mismatch %s: expected 0x%0h, got 0x%0h", name, expected, got);
        end
    endtask

    // Value only matters when the entry is valid
    task automatic check_value(input string port, input logic exp_vld,
            input logic [VALUE_WID-1:0] exp_val, input logic got_vld,
            input logic [VALUE_WID-1:0] got_val);
        checks++;
        if (got_vld !== exp_vld) begin
            errors++;
            $display("Mismatch %s_get_valid: expected 0x%0h, got 0x%0h", port, exp_vld, got_vld);
        end else if (exp_vld && got_val !== exp_val) begin
            errors++;
            $display("Mismatch %s_get_value: expected 0x%0h, got 0x%0h", port, exp_val, got_val);
        end
    endtask

    task automatic check_ack(input int port, input logic ack, input status_t st,
            input logic vld, input logic [VALUE_WID-1:0] val);
        if (ack) begin
            if (!outstanding[port]) begin
                flag_error($sformatf("Error: ack on %s port with no command of its own",
                    label_of(port)));
            end else begin
                check_status({label_of(port), "_status"}, exp_status[port], st);
                check_value(label_of(port), exp_valid[port], exp_value[port], vld, val);
                if (exp_cmd[port] != CLEAR && cyc - accept_cyc[port] != 2)
                    flag_error($sformatf("Error: %s ack came %0d cycles after accept, not 2",
                        label_of(port), cyc - accept_cyc[port]));
                ack_cyc[port]     = cyc;
                outstanding[port] = 1'b0;
            end
        end
    endtask

    task automatic end_test(input string name, input int start);
        tests_run++;
        if (errors == start)
            $display("Test %0d %s: ok", tests_run, name);
        else
            $display("Test %0d %s: %0d errors", tests_run, name, errors - start);
    endtask

    // ==========================================================
    // Controller drivers
    // ==========================================================

    task automatic drive_pins(input int port, input logic req, input command_t cmd,
            input logic [KEY_WID-1:0] key, input logic [VALUE_WID-1:0] value);
        if (port == LO) begin
            lo_req       = req;
            lo_command   = cmd;
            lo_key       = key;
            lo_set_value = value;
        end else begin
            hi_req       = req;
            hi_command   = cmd;
            hi_key       = key;
            hi_set_value = value;
        end
    endtask

    // The sweep clears one key per cycle before rdy may rise
    task automatic wait_ready();
        int waited;
        waited = 0;
        while (!hi_rdy && waited < RESET_TIMEOUT) begin
            @(negedge clk);
            waited++;
        end
        if (!hi_rdy) begin
            flag_error("Error: timeout, rdy never rose after the power-up clear");
            -> run_done;
        end else if (waited < 2**KEY_WID) begin
            flag_error($sformatf("Error: rdy rose %0d cycles after reset, before the clear ended",
                waited));
        end
    endtask

    task automatic send_command(input int port, input command_t cmd,
            input logic [KEY_WID-1:0] key, input logic [VALUE_WID-1:0] value);
        int                   waited;
        status_t              st;
        logic                 vld;
        logic [VALUE_WID-1:0] val;
        waited = 0;
        @(posedge clk);
        #DRIVE_DLY;
        drive_pins(port, 1'b1, cmd, key, value);
        @(negedge clk);
        while (!rdy_of(port) && waited < TIMEOUT_CYCLES) begin
            @(negedge clk);
            waited++;
        end
        if (!rdy_of(port)) begin
            flag_error($sformatf("Error: timeout, %s port command 0x%0h never accepted",
                label_of(port), cmd));
            -> run_done;
        end else begin
            // The model steps in accept order
            model_op(cmd, key, value, st, vld, val);
            exp_cmd[port]     = cmd;
            exp_status[port]  = st;
            exp_valid[port]   = vld;
            exp_value[port]   = val;
            accept_cyc[port]  = cyc;
            outstanding[port] = 1'b1;
            @(posedge clk);
            #DRIVE_DLY;
            drive_pins(port, 1'b0, cmd, key, value);
            waited = 0;
            while (outstanding[port] && waited < TIMEOUT_CYCLES) begin
                @(posedge clk);
                waited++;
            end
            if (outstanding[port]) begin
                flag_error($sformatf("Error: timeout, no ack on %s port", label_of(port)));
                -> run_done;
            end
        end
    endtask

    task automatic random_op(input int port);
        int       pick;
        command_t cmd;
        repeat ($urandom_range(0, 3)) @(posedge clk);
        pick = $urandom_range(0, 99);
        if (pick < 40)      cmd = GET;
        else if (pick < 68) cmd = SET;
        else if (pick < 83) cmd = UNSET;
        else if (pick < 91) cmd = NOP;
        else if (pick < 98) cmd = command_t'(3'($urandom_range(5, 7)));
        else                cmd = CLEAR;
        // Small key range so GETs hit stored entries
        send_command(port, cmd, KEY_WID'($urandom_range(0, 15)), VALUE_WID'($urandom()));
    endtask

`endif

//--- verif/db_subsys_tb.sv
module db_subsys_tb
    import db_pkg::*;
();

    localparam int  KEY_WID        = 8;
    localparam int  VALUE_WID      = 32;
    localparam int  SEED           = 38571;
    localparam int  TIMEOUT_CYCLES = 1000;
    localparam int  RESET_TIMEOUT  = 1000;
    localparam int  NUM_RANDOM_OPS = 200;
    localparam time DRIVE_DLY      = 1;
    localparam int  HI             = 0;
    localparam int  LO             = 1;

    logic                 clk;
    logic                 srst;
    logic                 hi_req;
    command_t             hi_command;
    logic [KEY_WID-1:0]   hi_key;
    logic [VALUE_WID-1:0] hi_set_value;
    logic                 hi_rdy;
    logic                 hi_ack;
    status_t              hi_status;
    logic                 hi_get_valid;
    logic [VALUE_WID-1:0] hi_get_value;
    logic                 lo_req;
    command_t             lo_command;
    logic [KEY_WID-1:0]   lo_key;
    logic [VALUE_WID-1:0] lo_set_value;
    logic                 lo_rdy;
    logic                 lo_ack;
    status_t              lo_status;
    logic                 lo_get_valid;
    logic [VALUE_WID-1:0] lo_get_value;

    // Per port bookkeeping, indexed by HI and LO
    command_t             exp_cmd     [2];
    status_t              exp_status  [2];
    logic                 exp_valid   [2];
    logic [VALUE_WID-1:0] exp_value   [2];
    logic                 outstanding [2];
    int                   accept_cyc  [2];
    int                   ack_cyc     [2];

    int   cyc       = 0;
    int   errors    = 0;
    int   checks    = 0;
    int   tests_run = 0;
    event run_done;

`include "db_subsys_tb_tasks.svh"

    always #4 clk = ~clk;

    always @(posedge clk) cyc <= cyc + 1;

    db_subsys_top #(
        .KEY_WID   ( KEY_WID ),
        .VALUE_WID ( VALUE_WID )
    ) u_db_subsys_top (
        .clk          ( clk ),
        .srst         ( srst ),
        .hi_req       ( hi_req ),
        .hi_command   ( hi_command ),
        .hi_key       ( hi_key ),
        .hi_set_value ( hi_set_value ),
        .hi_rdy       ( hi_rdy ),
        .hi_ack       ( hi_ack ),
        .hi_status    ( hi_status ),
        .hi_get_valid ( hi_get_valid ),
        .hi_get_value ( hi_get_value ),
        .lo_req       ( lo_req ),
        .lo_command   ( lo_command ),
        .lo_key       ( lo_key ),
        .lo_set_value ( lo_set_value ),
        .lo_rdy       ( lo_rdy ),
        .lo_ack       ( lo_ack ),
        .lo_status    ( lo_status ),
        .lo_get_valid ( lo_get_valid ),
        .lo_get_value ( lo_get_value )
    );

    // Responses compared mid cycle, away from the clock edge
    always @(negedge clk) begin
        if (!srst) begin
            check_ack(HI, hi_ack, hi_status, hi_get_valid, hi_get_value);
            check_ack(LO, lo_ack, lo_status, lo_get_valid, lo_get_value);
        end
    end

    initial begin
        @(run_done);
        $display("Tests run %0d, checks %0d, errors %0d", tests_run, checks, errors);
        if (errors == 0)
            $display("** PASS **");
        else
            $display("** FAIL **");
        $finish;
    end

    // ==========================================================
    // Test sequence
    // ==========================================================

    initial begin
        int start;
        void'($urandom(SEED));
        clk = 1'b0;
        srst = 1'b1;
        outstanding[HI] = 1'b0;
        outstanding[LO] = 1'b0;
        drive_pins(HI, 1'b0, NOP, '0, '0);
        drive_pins(LO, 1'b0, NOP, '0, '0);

        start = errors;
        repeat (5) @(posedge clk);
        #DRIVE_DLY;
        srst = 1'b0;
        @(negedge clk);
        if (hi_rdy || lo_rdy) flag_error("Error: rdy high while the power-up clear runs");
        wait_ready();
        for (int i = 0; i < 4; i++) send_command(HI, GET, KEY_WID'($urandom()), '0);
        end_test("power-up clear", start);

        start = errors;
        send_command(HI, SET, 8'h12, 32'hcafe_0012);
        send_command(HI, GET, 8'h12, '0);
        send_command(LO, UNSET, 8'h12, '0);
        send_command(LO, GET, 8'h12, '0);
        end_test("set get unset", start);

        start = errors;
        for (int i = 0; i < 6; i++) send_command(HI, SET, KEY_WID'(8'h20 + i), VALUE_WID'($urandom()));
        send_command(LO, CLEAR, '0, '0);
        for (int i = 0; i < 6; i++) send_command(HI, GET, KEY_WID'(8'h20 + i), '0);
        end_test("latency and clear", start);

        start = errors;
        send_command(HI, SET, 8'h40, 32'h1234_5678);
        send_command(HI, command_t'(3'd5), 8'h40, 32'hdead_beef);
        send_command(LO, command_t'(3'd7), 8'h40, 32'h0bad_0bad);
        send_command(LO, GET, 8'h40, '0);
        end_test("illegal command", start);

        // Same-cycle requests from both controllers
        start = errors;
        fork
            send_command(HI, SET, 8'h55, 32'h5555_aaaa);
            send_command(LO, GET, 8'h55, '0);
        join
        if (!(accept_cyc[HI] < accept_cyc[LO] && accept_cyc[LO] > ack_cyc[HI]))
            flag_error("Error: low-priority port accepted before the high-priority ack");
        end_test("priority", start);

        start = errors;
        fork
            repeat (NUM_RANDOM_OPS / 2) random_op(HI);
            repeat (NUM_RANDOM_OPS / 2) random_op(LO);
        join
        end_test("random traffic", start);

        -> run_done;
    end

endmodule : db_subsys_tb

//--- verilog/db_store_array.sv
module db_store_array #(
    parameter int KEY_WID   = 8,
    parameter int VALUE_WID = 32
) (
    input  logic                 clk,
    input  logic                 srst,
    input  logic                 init,
    output logic                 init_done,
    input  logic                 wr_en,
    input  logic [KEY_WID-1:0]   wr_key,
    input  logic                 wr_valid,
    input  logic [VALUE_WID-1:0] wr_value,
    input  logic                 rd_en,
    input  logic [KEY_WID-1:0]   rd_key,
    output logic                 rd_valid_out,
    output logic [VALUE_WID-1:0] rd_value
);

    localparam int SIZE = 2**KEY_WID;

    logic                 valid_mem [SIZE];
    logic [VALUE_WID-1:0] value_mem [SIZE];

    logic                 sweeping;
    logic [KEY_WID-1:0]   sweep_key;

    // ==========================================================
    // Init sweep
    // ==========================================================

    // Done on the cycle that clears the last key
    assign init_done = sweeping && (&sweep_key);

    always_ff @(posedge clk) begin
        if (srst) begin
            sweeping  <= 1'b0;
            sweep_key <= '0;
        end else if (sweeping) begin
            sweep_key <= sweep_key + 1'b1;
            if (&sweep_key) sweeping <= 1'b0;
        end else if (init) begin
            sweeping  <= 1'b1;
            sweep_key <= '0;
        end
    end

    // ==========================================================
    // Storage
    // ==========================================================

    always_ff @(posedge clk) begin
        if (sweeping) begin
            valid_mem[sweep_key] <= 1'b0;
        end else if (wr_en) begin
            valid_mem[wr_key] <= wr_valid;
        end
        if (wr_en) value_mem[wr_key] <= wr_value;
    end

    // One cycle read
    always_ff @(posedge clk) begin
        if (rd_en) begin
            rd_valid_out <= valid_mem[rd_key];
            rd_value     <= value_mem[rd_key];
        end
    end

    a_no_wr_in_sweep : assert property (
        @(posedge clk) disable iff (srst) wr_en |-> !sweeping
    );

endmodule : db_store_array

//--- verilog/db_subsys_top.sv
module db_subsys_top
    import db_pkg::*;
#(
    parameter int KEY_WID   = 8,
    parameter int VALUE_WID = 32
) (
    input  logic                 clk,
    input  logic                 srst,

    input  logic                 hi_req,
    input  command_t             hi_command,
    input  logic [KEY_WID-1:0]   hi_key,
    input  logic [VALUE_WID-1:0] hi_set_value,
    output logic                 hi_rdy,
    output logic                 hi_ack,
    output status_t              hi_status,
    output logic                 hi_get_valid,
    output logic [VALUE_WID-1:0] hi_get_value,

    input  logic                 lo_req,
    input  command_t             lo_command,
    input  logic [KEY_WID-1:0]   lo_key,
    input  logic [VALUE_WID-1:0] lo_set_value,
    output logic                 lo_rdy,
    output logic                 lo_ack,
    output status_t              lo_status,
    output logic                 lo_get_valid,
    output logic [VALUE_WID-1:0] lo_get_value
);

    // Merged control port
    logic                 per_req;
    command_t             per_command;
    logic [KEY_WID-1:0]   per_key;
    logic [VALUE_WID-1:0] per_set_value;
    logic                 per_rdy;
    logic                 per_ack;
    status_t              per_status;
    logic                 per_get_valid;
    logic [VALUE_WID-1:0] per_get_value;

    // Store ports
    logic                 init;
    logic                 init_done;
    logic                 wr_en;
    logic [KEY_WID-1:0]   wr_key;
    logic                 wr_valid;
    logic [VALUE_WID-1:0] wr_value;
    logic                 rd_en;
    logic [KEY_WID-1:0]   rd_key;
    logic                 rd_valid_out;
    logic [VALUE_WID-1:0] rd_value;

    db_ctrl_prio_mux #(
        .KEY_WID   ( KEY_WID ),
        .VALUE_WID ( VALUE_WID )
    ) u_db_ctrl_prio_mux (
        .clk           ( clk ),
        .srst          ( srst ),
        .hi_req        ( hi_req ),
        .hi_command    ( hi_command ),
        .hi_key        ( hi_key ),
        .hi_set_value  ( hi_set_value ),
        .hi_rdy        ( hi_rdy ),
        .hi_ack        ( hi_ack ),
        .hi_status     ( hi_status ),
        .hi_get_valid  ( hi_get_valid ),
        .hi_get_value  ( hi_get_value ),
        .lo_req        ( lo_req ),
        .lo_command    ( lo_command ),
        .lo_key        ( lo_key ),
        .lo_set_value  ( lo_set_value ),
        .lo_rdy        ( lo_rdy ),
        .lo_ack        ( lo_ack ),
        .lo_status     ( lo_status ),
        .lo_get_valid  ( lo_get_valid ),
        .lo_get_value  ( lo_get_value ),
        .per_req       ( per_req ),
        .per_command   ( per_command ),
        .per_key       ( per_key ),
        .per_set_value ( per_set_value ),
        .per_rdy       ( per_rdy ),
        .per_ack       ( per_ack ),
        .per_status    ( per_status ),
        .per_get_valid ( per_get_valid ),
        .per_get_value ( per_get_value )
    );

    db_ctrl_peripheral #(
        .KEY_WID   ( KEY_WID ),
        .VALUE_WID ( VALUE_WID )
    ) u_db_ctrl_peripheral (
        .clk          ( clk ),
        .srst         ( srst ),
        .req          ( per_req ),
        .command      ( per_command ),
        .key          ( per_key ),
        .set_value    ( per_set_value ),
        .rdy          ( per_rdy ),
        .ack          ( per_ack ),
        .status       ( per_status ),
        .get_valid    ( per_get_valid ),
        .get_value    ( per_get_value ),
        .init         ( init ),
        .init_done    ( init_done ),
        .wr_en        ( wr_en ),
        .wr_key       ( wr_key ),
        .wr_valid     ( wr_valid ),
        .wr_value     ( wr_value ),
        .rd_en        ( rd_en ),
        .rd_key       ( rd_key ),
        .rd_valid_out ( rd_valid_out ),
        .rd_value     ( rd_value )
    );

    db_store_array #(
        .KEY_WID   ( KEY_WID ),
        .VALUE_WID ( VALUE_WID )
    ) u_db_store_array (
        .clk          ( clk ),
        .srst         ( srst ),
        .init         ( init ),
        .init_done    ( init_done ),
        .wr_en        ( wr_en ),
        .wr_key       ( wr_key ),
        .wr_valid     ( wr_valid ),
        .wr_value     ( wr_value ),
        .rd_en        ( rd_en ),
        .rd_key       ( rd_key ),
        .rd_valid_out ( rd_valid_out ),
        .rd_value     ( rd_value )
    );

endmodule : db_subsys_top
